//--- Bender.yml
package:
  name: trav

sources:
  - source/trav_pkg.sv
  - source/mem_port.sv
  - source/link_reversal.sv
  - source/trav_sequencer.sv
  - source/trav_top.sv
  - target: test
    files:
      - dv/trav_assertions.sv
      - dv/trav_tb.sv

//--- compile.f
source/trav_pkg.sv
source/mem_port.sv
source/link_reversal.sv
source/trav_sequencer.sv
source/trav_top.sv
dv/trav_assertions.sv
dv/trav_tb.sv

//--- dv/trav_assertions.sv
`timescale 1ns/10ps

module trav_assertions (
  input logic clk,
  input logic rst,
  input logic run,
  input logic done,
  input logic mem_req,
  input logic mem_ready
);

  // High from the request cycle until the ready pulse
  logic outstanding;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      outstanding <= 1'b0;
    end else if (mem_req) begin
      outstanding <= 1'b1;
    end else if (mem_ready) begin
      outstanding <= 1'b0;
    end
  end

  a_single_request: assert property (@(posedge clk) disable iff (!rst)
    mem_req |-> !outstanding)
    else $error("memory request issued while another is outstanding");

  a_request_pulse: assert property (@(posedge clk) disable iff (!rst)
    mem_req |=> !mem_req)
    else $error("memory request held longer than one cycle");

  a_done_needs_run: assert property (@(posedge clk) disable iff (!rst)
    $rose(done) |-> $past(run))
    else $error("done rose while run was low");

  a_quiet_when_done: assert property (@(posedge clk) disable iff (!rst)
    done |-> !mem_req)
    else $error("memory request issued while done is high");

endmodule

bind trav_top trav_assertions i_trav_assertions (
  .clk      (clk),
  .rst      (rst),
  .run      (run),
  .done     (done),
  .mem_req  (mem_req),
  .mem_ready(mem_ready)
);

//--- dv/trav_tb.sv
`timescale 1ns/10ps

module trav_tb;
  import trav_pkg::*;

  localparam int addr_width = 10;
  localparam int word_width = tag_width + 2 * addr_width;
  localparam int depth      = 1 << addr_width;
  localparam int wait_limit = 2000;

  logic                  clk;
  logic                  rst;
  logic                  run;
  logic [addr_width-1:0] start_addr;
  logic                  mem_ready;
  logic [word_width-1:0] read_data;
  logic                  done;
  logic                  mem_req;
  mem_func_t             mem_func;
  logic [addr_width-1:0] address;
  logic [word_width-1:0] write_data;

  logic [word_width-1:0] mem [depth];
  logic [word_width-1:0] image [depth];
  logic [31:0]           tests [256];
  logic [31:0]           rng;
  int                    reads;
  int                    writes;
  int                    value_errors;
  int                    other_errors;
  logic                  timed_out;

  trav_top #(
    .addr_width(addr_width)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .start_addr(start_addr),
    .mem_ready (mem_ready),
    .read_data (read_data),
    .done      (done),
    .mem_req   (mem_req),
    .mem_func  (mem_func),
    .address   (address),
    .write_data(write_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("Fail %s: got %h expected %h", name, got, expected);
      value_errors++;
    end
  endtask

  task automatic check_idle(input string phase);
    if (done !== 1'b0) begin
      $display("Fail done %s: got %h expected %h", phase, done, 1'b0);
      value_errors++;
    end
    if (mem_req !== 1'b0) begin
      $display("Fail mem_req %s: got %h expected %h", phase, mem_req, 1'b0);
      value_errors++;
    end
  endtask

  // Words never reached by a walk still differ per address
  task automatic fill_memory();
    for (int a = 0; a < depth; a++) begin
      mem[a] = {8'h5a, a[addr_width-1:0], a[addr_width-1:0] ^ 10'h2b7};
    end
  endtask

  task automatic compare_memory();
    for (int a = 0; a < depth; a++) begin
      if (mem[a] !== image[a]) begin
        $display("Fail mem[%h]: got %h expected %h", a[addr_width-1:0], mem[a], image[a]);
        value_errors++;
      end
    end
  endtask

  // Memory model answers each request after 1 to 4 cycles
  initial begin : memory_model
    logic                  pend;
    int                    cnt;
    logic                  p_write;
    logic [addr_width-1:0] p_addr;
    logic [word_width-1:0] p_data;
    mem_ready = 1'b0;
    read_data = '0;
    pend      = 1'b0;
    cnt       = 0;
    p_write   = 1'b0;
    p_addr    = '0;
    p_data    = '0;
    rng       = 32'd87196;
    forever begin
      @(negedge clk);
      mem_ready = 1'b0;
      read_data = '0;
      if (pend) begin
        cnt--;
        if (cnt == 0) begin
          mem_ready = 1'b1;
          pend      = 1'b0;
          if (p_write) begin
            mem[p_addr] = p_data;
            writes++;
          end else begin
            read_data = mem[p_addr];
            reads++;
          end
        end
      end
      if (mem_req) begin
        if (mem_func != func_get_contents && mem_func != func_set_contents) begin
          $display("Fail mem_func: got %h expected %h or %h", mem_func,
                   func_get_contents, func_set_contents);
          value_errors++;
        end
        rng     = xorshift32(rng);
        cnt     = 1 + int'(rng % 4);
        pend    = 1'b1;
        p_write = (mem_func == func_set_contents);
        p_addr  = address;
        p_data  = write_data;
      end
    end
  end

  initial begin : stimulus
    int          idx;
    int          cycles;
    logic [31:0] root;
    logic [31:0] exp_reads;
    logic [31:0] exp_writes;
    rst          = 1'b0;
    run          = 1'b0;
    start_addr   = '0;
    reads        = 0;
    writes       = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    foreach (tests[i]) begin
      tests[i] = '1;
    end
    $readmemh("dv/trav_tests.dat", tests);

    repeat (10) begin
      @(negedge clk);
      check_idle("during reset");
    end
    rst = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_idle("before run");
    end

    idx = 0;
    while (tests[idx] != 32'hffffffff && !timed_out) begin
      root       = tests[idx];
      exp_reads  = tests[idx+1];
      exp_writes = tests[idx+2];
      idx += 3;
      fill_memory();
      while (tests[idx] != 32'hffffffff) begin
        mem[tests[idx][addr_width-1:0]] = tests[idx+1][word_width-1:0];
        idx += 2;
      end
      idx++;
      image  = mem;
      reads  = 0;
      writes = 0;

      start_addr = root[addr_width-1:0];
      run        = 1'b1;
      cycles     = 0;
      while (!done && cycles < wait_limit) begin
        @(negedge clk);
        cycles++;
      end
      if (!done) begin
        $display("Timeout: walk from root %h never raised done", root);
        other_errors++;
        timed_out = 1'b1;
      end else begin
        check_value("reads", reads, exp_reads);
        check_value("writes", writes, exp_writes);
        compare_memory();
        // done holds while run stays high
        @(negedge clk);
        if (done !== 1'b1) begin
          $display("Fail done with run still high: got %h expected %h", done, 1'b1);
          value_errors++;
        end
        run    = 1'b0;
        cycles = 0;
        while (done && cycles < wait_limit) begin
          @(negedge clk);
          cycles++;
        end
        if (done) begin
          $display("Timeout: done stayed high after run went low");
          other_errors++;
          timed_out = 1'b1;
        end
      end
    end

    // Run dropped right after the start so the walk ends without done
    if (!timed_out) begin
      reads  = 0;
      writes = 0;
      run    = 1'b1;
      @(negedge clk);
      run    = 1'b0;
      cycles = 0;
      while ((reads != exp_reads || writes != exp_writes) && cycles < wait_limit) begin
        @(negedge clk);
        cycles++;
      end
      if (reads != exp_reads || writes != exp_writes) begin
        $display("Timeout: walk with run dropped early never finished its accesses");
        other_errors++;
      end
      repeat (4) begin
        @(negedge clk);
        check_idle("after a walk with run low");
      end
      compare_memory();
    end

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- dv/trav_tests.dat
// Each test starts with root address then expected reads and expected writes
// Then address and cell word pairs until a line of ffffffff
// Single atom/atom root with tag bit 7 set
010 1 0
010 8048C45
ffffffff
// Root cell/cell over cell/atom and atom/cell branches
100 9 7
100 8340502
101 1240FAA
102 8115504
103 4000402
104 00FFC00
ffffffff
// Two levels of cell/cell from another root
200 b 8
200 0380602
201 E380E04
202 0044622
203 0100205
204 80FFBFF
205 702ACCD
ffffffff
// Head then tail chain ending at address zero
300 5 4
300 02C0400
301 81A9400
000 20FFFFF
ffffffff
ffffffff

//--- source/link_reversal.sv
`timescale 1ns/10ps

module link_reversal #(
  parameter int addr_width = 10
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      begin_walk,
  input  logic [addr_width-1:0]                     start_addr,
  input  logic                                      load,
  input  logic [trav_pkg::tag_width+2*addr_width-1:0] rsp_word,
  input  logic                                      step,
  output logic [addr_width-1:0]                     cmd_addr,
  output logic [trav_pkg::tag_width+2*addr_width-1:0] cmd_word,
  output logic                                      need_write,
  output logic                                      at_end,
  output logic                                      tel_pending
);
  import trav_pkg::*;

  localparam int word_width = tag_width + 2 * addr_width;
  localparam logic [addr_width-1:0] nil = '1;

  // Current cell
  logic [addr_width-1:0] cur_addr;
  logic [tag_width-1:0]  cur_tag;
  logic [addr_width-1:0] cur_hed;
  logic [addr_width-1:0] cur_tel;

  // P is the next read, B the return path (or the child just left)
  logic [addr_width-1:0] reg_p;
  logic [addr_width-1:0] reg_b;

  // Tail push owed after a head restore
  logic tel_next;
  // Write-back address is needed in the cycle after a writing step
  logic wr_sel;

  logic [1:0] kind;
  logic       push_hed;
  logic       push_tel;
  logic       ret_hed;
  logic       pop;
  logic [addr_width-1:0] pop_target;

  assign kind = cur_tag[1:0];

  always_comb begin
    push_hed = 1'b0;
    push_tel = 1'b0;
    ret_hed  = 1'b0;
    pop      = 1'b0;
    if (tel_next) begin
      push_tel = 1'b1;
    end else if (kind[1] && !cur_tag[visited_hed_bit]) begin
      push_hed = 1'b1;
    end else if (kind == kind_cell_cell && !cur_tag[visited_tel_bit]) begin
      ret_hed = 1'b1;
    end else if (kind == kind_atom_cell && !cur_tag[visited_tel_bit]) begin
      push_tel = 1'b1;
    end else begin
      pop = 1'b1;
    end
  end

  // Reversed field holds the parent, atom/atom cells go straight back to B
  assign pop_target = kind[0] ? cur_tel : (kind[1] ? cur_hed : reg_b);

  assign need_write  = push_hed || push_tel || (pop && kind != kind_atom_atom);
  assign at_end      = pop && (pop_target == nil);
  assign tel_pending = ret_hed;

  assign cmd_addr = wr_sel ? cur_addr : reg_p;
  assign cmd_word = {cur_tag, cur_hed, cur_tel};

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      tel_next <= 1'b0;
      wr_sel   <= 1'b0;
    end else begin
      wr_sel <= step && need_write;
      if (begin_walk) begin
        tel_next <= 1'b0;
      end else if (step) begin
        tel_next <= ret_hed;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (begin_walk) begin
      cur_addr <= start_addr;
      reg_p    <= start_addr;
      reg_b    <= nil;
    end else if (load) begin
      cur_addr                     <= reg_p;
      {cur_tag, cur_hed, cur_tel}  <= rsp_word[word_width-1:0];
    end else if (step) begin
      if (push_hed) begin
        cur_tag[visited_hed_bit] <= 1'b1;
        cur_hed                  <= reg_b;
        reg_p                    <= cur_hed;
        reg_b                    <= cur_addr;
      end else if (push_tel) begin
        cur_tag[visited_tel_bit] <= 1'b1;
        cur_tel                  <= reg_b;
        reg_p                    <= cur_tel;
        reg_b                    <= cur_addr;
      end else if (ret_hed) begin
        // Head back in place, parent moves to B for the tail push
        cur_hed <= reg_b;
        reg_b   <= cur_hed;
      end else begin
        cur_tag[visited_hed_bit] <= 1'b0;
        cur_tag[visited_tel_bit] <= 1'b0;
        if (kind[0]) begin
          cur_tel <= reg_b;
        end else if (kind[1]) begin
          cur_hed <= reg_b;
        end
        reg_p <= pop_target;
        reg_b <= cur_addr;
      end
    end
  end

endmodule

//--- source/mem_port.sv
`timescale 1ns/10ps

module mem_port #(
  parameter int addr_width = 10
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      cmd_valid,
  input  logic                                      cmd_write,
  input  logic [addr_width-1:0]                     cmd_addr,
  input  logic [trav_pkg::tag_width+2*addr_width-1:0] cmd_word,
  input  logic                                      mem_ready,
  input  logic [trav_pkg::tag_width+2*addr_width-1:0] read_data,
  output logic                                      mem_req,
  output trav_pkg::mem_func_t                       mem_func,
  output logic [addr_width-1:0]                     address,
  output logic [trav_pkg::tag_width+2*addr_width-1:0] write_data,
  output logic                                      rsp_valid,
  output logic [trav_pkg::tag_width+2*addr_width-1:0] rsp_word
);
  import trav_pkg::*;

  localparam int word_width = tag_width + 2 * addr_width;

  // Request outstanding
  logic busy;
  // Outstanding request is a write
  logic wr_pend;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mem_req    <= 1'b0;
      mem_func   <= '0;
      address    <= '0;
      write_data <= '0;
      rsp_valid  <= 1'b0;
      busy       <= 1'b0;
      wr_pend    <= 1'b0;
    end else begin
      mem_req   <= 1'b0;
      rsp_valid <= 1'b0;
      // Fields are only held for the request cycle
      mem_func   <= '0;
      address    <= '0;
      write_data <= '0;
      if (busy && mem_ready) begin
        busy      <= 1'b0;
        rsp_valid <= 1'b1;
      end
      if (cmd_valid && !busy) begin
        mem_req    <= 1'b1;
        mem_func   <= cmd_write ? func_set_contents : func_get_contents;
        address    <= cmd_addr;
        write_data <= cmd_write ? cmd_word : {word_width{1'b0}};
        busy       <= 1'b1;
        wr_pend    <= cmd_write;
      end
    end
  end

  // Read word, taken on the ready pulse
  always_ff @(posedge clk) begin
    if (busy && mem_ready && !wr_pend) begin
      rsp_word <= read_data;
    end
  end

endmodule

//--- source/trav_pkg.sv
package trav_pkg;

  // Cell word is {tag, hed, tel}, tag in the top bits
  localparam int tag_width = 8;

  // Tag bits 1:0 give what the head and tail fields hold
  // Bit 1 set means the head points to a cell
  // Bit 0 set means the tail points to a cell
  localparam logic [1:0] kind_atom_atom = 2'b00;
  localparam logic [1:0] kind_atom_cell = 2'b01;
  localparam logic [1:0] kind_cell_atom = 2'b10;
  localparam logic [1:0] kind_cell_cell = 2'b11;

  // Visited marks used while the walk is inside a cell
  localparam int visited_hed_bit = 3;
  localparam int visited_tel_bit = 2;

  // Memory function codes, zero is no function
  typedef logic [1:0] mem_func_t;

  localparam mem_func_t func_get_contents = 2'b01;
  localparam mem_func_t func_set_contents = 2'b10;

endpackage

//--- source/trav_sequencer.sv
`timescale 1ns/10ps

module trav_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic rsp_valid,
  input  logic need_write,
  input  logic at_end,
  input  logic tel_pending,
  output logic begin_walk,
  output logic cmd_valid,
  output logic cmd_write,
  output logic load,
  output logic step,
  output logic done
);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_issue,
    st_rd_wait,
    st_step,
    st_wr_issue,
    st_wr_wait,
    st_tel_step,
    st_finished
  } state_t;

  state_t state;
  state_t state_nxt;
  state_t fin_state;

  // Last write-back closes the walk
  logic end_pend;

  // Run dropped before the end means no done pulse
  assign fin_state = run ? st_finished : st_idle;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (run) begin
          state_nxt = st_rd_issue;
        end
      end
      st_rd_issue: state_nxt = st_rd_wait;
      st_rd_wait: begin
        if (rsp_valid) begin
          state_nxt = st_step;
        end
      end
      st_step, st_tel_step: begin
        if (tel_pending) begin
          state_nxt = st_tel_step;
        end else if (need_write) begin
          state_nxt = st_wr_issue;
        end else if (at_end) begin
          state_nxt = fin_state;
        end else begin
          state_nxt = st_rd_issue;
        end
      end
      st_wr_issue: state_nxt = st_wr_wait;
      st_wr_wait: begin
        if (rsp_valid) begin
          state_nxt = end_pend ? fin_state : st_rd_issue;
        end
      end
      st_finished: begin
        if (!run) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state    <= st_idle;
      end_pend <= 1'b0;
    end else begin
      state <= state_nxt;
      if ((state == st_step || state == st_tel_step) && need_write) begin
        end_pend <= at_end;
      end
    end
  end

  assign begin_walk = (state == st_idle) && run;
  assign cmd_valid  = (state == st_rd_issue) || (state == st_wr_issue);
  assign cmd_write  = (state == st_wr_issue);
  assign load       = (state == st_rd_wait) && rsp_valid;
  assign step       = (state == st_step) || (state == st_tel_step);
  assign done       = (state == st_finished);

endmodule

//--- source/trav_top.sv
`timescale 1ns/10ps

module trav_top #(
  parameter int addr_width = 10
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      run,
  input  logic [addr_width-1:0]                     start_addr,
  input  logic                                      mem_ready,
  input  logic [trav_pkg::tag_width+2*addr_width-1:0] read_data,
  output logic                                      done,
  output logic                                      mem_req,
  output trav_pkg::mem_func_t                       mem_func,
  output logic [addr_width-1:0]                     address,
  output logic [trav_pkg::tag_width+2*addr_width-1:0] write_data
);
  import trav_pkg::*;

  localparam int word_width = tag_width + 2 * addr_width;

  logic                  begin_walk;
  logic                  cmd_valid;
  logic                  cmd_write;
  logic                  load;
  logic                  step;
  logic                  rsp_valid;
  logic                  need_write;
  logic                  at_end;
  logic                  tel_pending;
  logic [addr_width-1:0] cmd_addr;
  logic [word_width-1:0] cmd_word;
  logic [word_width-1:0] rsp_word;

  // Memory handshake
  mem_port #(
    .addr_width(addr_width)
  ) i_mem_port (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_word  (cmd_word),
    .mem_ready (mem_ready),
    .read_data (read_data),
    .mem_req   (mem_req),
    .mem_func  (mem_func),
    .address   (address),
    .write_data(write_data),
    .rsp_valid (rsp_valid),
    .rsp_word  (rsp_word)
  );

  // Cell and pointer datapath
  link_reversal #(
    .addr_width(addr_width)
  ) i_link_reversal (
    .clk        (clk),
    .rst        (rst),
    .begin_walk (begin_walk),
    .start_addr (start_addr),
    .load       (load),
    .rsp_word   (rsp_word),
    .step       (step),
    .cmd_addr   (cmd_addr),
    .cmd_word   (cmd_word),
    .need_write (need_write),
    .at_end     (at_end),
    .tel_pending(tel_pending)
  );

  trav_sequencer i_trav_sequencer (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .rsp_valid  (rsp_valid),
    .need_write (need_write),
    .at_end     (at_end),
    .tel_pending(tel_pending),
    .begin_walk (begin_walk),
    .cmd_valid  (cmd_valid),
    .cmd_write  (cmd_write),
    .load       (load),
    .step       (step),
    .done       (done)
  );

endmodule
